// File: hdl/acc_cpu.sv
// ############################
// Accumulator processor
// LDI, ADDI, STA and JMP over the pin bus
// ############################
`timescale 1ns/1ps
`include "cpu_bus_settings.svh"

module acc_cpu (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      step,
  input  cpu_bus_pkg::word_t        rdata,
  output cpu_bus_pkg::cpu_bus_req_t bus_req
);

  typedef enum logic {
    CPU_FETCH,
    CPU_STORE
  } cpu_state_e;

  cpu_state_e                cpu_state;
  cpu_state_e                cpu_state_nxt;
  cpu_bus_pkg::word_t        pc;
  cpu_bus_pkg::word_t        pc_nxt;
  cpu_bus_pkg::word_t        acc;
  cpu_bus_pkg::word_t        acc_nxt;
  cpu_bus_pkg::cpu_bus_req_t req_nxt;

  cpu_bus_pkg::opcode_t      opcode;
  cpu_bus_pkg::imm_t         imm;
  cpu_bus_pkg::word_t        imm_ext;

  // Instruction fields
  assign opcode  = rdata[`CPU_WORD_W-1 -: 8];
  assign imm     = rdata[23:0];
  assign imm_ext = cpu_bus_pkg::word_t'(imm);  // Zero-extended

  always_comb begin
    cpu_state_nxt = cpu_state;
    pc_nxt        = pc;
    acc_nxt       = acc;
    req_nxt       = bus_req;

    if (cpu_state == CPU_STORE) begin
      // Read word of a write cycle carries nothing
      cpu_state_nxt = CPU_FETCH;
      req_nxt.addr  = pc;
      req_nxt.wdata = '0;
      req_nxt.rw    = 1'b0;
    end else begin
      case (opcode)
        `OP_LDI: begin
          acc_nxt = imm_ext;
          pc_nxt  = pc + 1'b1;
        end
        `OP_ADDI: begin
          acc_nxt = acc + imm_ext;  // Wraps modulo 2^32
          pc_nxt  = pc + 1'b1;
        end
        `OP_JMP: begin
          pc_nxt = imm_ext;
        end
        `OP_STA: begin
          pc_nxt = pc + 1'b1;
        end
        default: begin
          pc_nxt = pc + 1'b1;  // No-op
        end
      endcase

      if (opcode == `OP_STA) begin
        cpu_state_nxt = CPU_STORE;
        req_nxt.addr  = imm_ext;
        req_nxt.wdata = acc;      // Value before this step
        req_nxt.rw    = 1'b1;
      end else begin
        req_nxt.addr  = pc_nxt;   // Word address of next fetch
        req_nxt.wdata = '0;
        req_nxt.rw    = 1'b0;
      end
    end
  end

  // Request held stable between steps
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cpu_state <= CPU_FETCH;
      pc        <= '0;
      acc       <= '0;
      bus_req   <= '0;
    end else if (step) begin
      cpu_state <= cpu_state_nxt;
      pc        <= pc_nxt;
      acc       <= acc_nxt;
      bus_req   <= req_nxt;
    end
  end

endmodule

// File: hdl/bus_in_assembler.sv
// ############################
// Bus input assembler
// Read word built from four pin bytes
// ############################
`timescale 1ns/1ps
`include "cpu_bus_settings.svh"

module bus_in_assembler (
  input  logic                    clk,
  input  logic                    rst_n,
  input  cpu_bus_pkg::bus_phase_e phase,
  input  cpu_bus_pkg::pin_byte_t  uio_in,
  output cpu_bus_pkg::word_t      rdata
);

  localparam int LANE_W = $clog2(`CPU_WORD_W / `CPU_PIN_W);

  logic              in_sel;  // High in PH_IN0..PH_IN3
  logic [LANE_W-1:0] lane;

  always_comb begin
    in_sel = 1'b1;
    lane   = '0;
    case (phase)
      cpu_bus_pkg::PH_IN0: lane = LANE_W'(0);  // Least significant byte first
      cpu_bus_pkg::PH_IN1: lane = LANE_W'(1);
      cpu_bus_pkg::PH_IN2: lane = LANE_W'(2);
      cpu_bus_pkg::PH_IN3: lane = LANE_W'(3);
      default:             in_sel = 1'b0;
    endcase
  end

  // Holding register stays put from PH_IN3 to the next PH_IN0
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rdata <= '0;  // First step sees a no-op
    end else if (in_sel) begin
      rdata[lane*`CPU_PIN_W +: `CPU_PIN_W] <= uio_in;
    end
  end

endmodule

// File: hdl/bus_out_serializer.sv
// ############################
// Bus output serializer
// Address and write data onto the pins, one lane per phase
// ############################
`timescale 1ns/1ps
`include "cpu_bus_settings.svh"

module bus_out_serializer (
  input  logic                     clk,
  input  logic                     rst_n,
  input  cpu_bus_pkg::bus_phase_e  phase,
  input  cpu_bus_pkg::cpu_bus_req_t bus_req,
  output cpu_bus_pkg::pin_byte_t   uo_out,
  output cpu_bus_pkg::pin_byte_t   uio_out,
  output cpu_bus_pkg::pin_byte_t   uio_oe
);

  localparam int LANE_W = $clog2(`CPU_WORD_W / `CPU_PIN_W);

  logic              out_sel;  // High in PH_OUT0..PH_OUT3
  logic [LANE_W-1:0] lane;

  always_comb begin
    out_sel = 1'b1;
    lane    = '0;
    case (phase)
      cpu_bus_pkg::PH_OUT0: lane = LANE_W'(0);
      cpu_bus_pkg::PH_OUT1: lane = LANE_W'(1);
      cpu_bus_pkg::PH_OUT2: lane = LANE_W'(2);
      cpu_bus_pkg::PH_OUT3: lane = LANE_W'(3);
      default:              out_sel = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      uo_out  <= '0;
      uio_out <= '0;
      uio_oe  <= '0;
    end else begin
      // Enable tracks the held request for the whole cycle
      uio_oe <= {`CPU_PIN_W{bus_req.rw}};
      if (out_sel) begin
        uo_out  <= bus_req.addr[lane*`CPU_PIN_W +: `CPU_PIN_W];   // Clean 8-bit slice
        uio_out <= bus_req.wdata[lane*`CPU_PIN_W +: `CPU_PIN_W];
      end
    end
  end

endmodule

// File: hdl/bus_phase_ctrl.sv
// ############################
// Bus phase sequencer
// Nine-phase bus cycle and processor step pulse
// ############################
`timescale 1ns/1ps

module bus_phase_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,
  output cpu_bus_pkg::bus_phase_e phase,
  output logic                   step
);

  cpu_bus_pkg::bus_phase_e phase_nxt;

  // Fixed order, wraps after the last read byte
  always_comb begin
    case (phase)
      cpu_bus_pkg::PH_STEP: phase_nxt = cpu_bus_pkg::PH_OUT0;
      cpu_bus_pkg::PH_OUT0: phase_nxt = cpu_bus_pkg::PH_OUT1;
      cpu_bus_pkg::PH_OUT1: phase_nxt = cpu_bus_pkg::PH_OUT2;
      cpu_bus_pkg::PH_OUT2: phase_nxt = cpu_bus_pkg::PH_OUT3;
      cpu_bus_pkg::PH_OUT3: phase_nxt = cpu_bus_pkg::PH_IN0;
      cpu_bus_pkg::PH_IN0:  phase_nxt = cpu_bus_pkg::PH_IN1;
      cpu_bus_pkg::PH_IN1:  phase_nxt = cpu_bus_pkg::PH_IN2;
      cpu_bus_pkg::PH_IN2:  phase_nxt = cpu_bus_pkg::PH_IN3;
      cpu_bus_pkg::PH_IN3:  phase_nxt = cpu_bus_pkg::PH_STEP;
      default:              phase_nxt = cpu_bus_pkg::PH_STEP;  // Recover from unused codes
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      phase <= cpu_bus_pkg::PH_STEP;
    end else begin
      phase <= phase_nxt;
    end
  end

  // Processor advances once per bus cycle
  assign step = (phase == cpu_bus_pkg::PH_STEP);

endmodule

// File: hdl/cpu_bus_pkg.sv
// ############################
// CPU pin bus types
// Shared vectors, phase enum and bus request
// ############################
`include "cpu_bus_settings.svh"

package cpu_bus_pkg;

  typedef logic [`CPU_WORD_W-1:0] word_t;      // Address, data or instruction
  typedef logic [`CPU_PIN_W-1:0]  pin_byte_t;  // One pin lane
  typedef logic [7:0]             opcode_t;    // Instruction bits 31..24
  typedef logic [23:0]            imm_t;       // Instruction bits 23..0

  // Phase order within one bus cycle
  typedef enum logic [$clog2(`BUS_PHASES)-1:0] {
    PH_STEP,
    PH_OUT0,
    PH_OUT1,
    PH_OUT2,
    PH_OUT3,
    PH_IN0,
    PH_IN1,
    PH_IN2,
    PH_IN3
  } bus_phase_e;

  typedef struct packed {
    word_t addr;   // Byte lanes go out least significant first
    word_t wdata;  // Zero on fetch cycles
    logic  rw;     // 1 for write
  } cpu_bus_req_t;

endpackage

// File: hdl/cpu_bus_settings.svh
// ############################
// CPU pin bus settings
// Word, pin and phase sizes plus opcode values
// ############################
`ifndef CPU_BUS_SETTINGS_SVH
`define CPU_BUS_SETTINGS_SVH

`define CPU_WORD_W 32   // Address and data width
`define CPU_PIN_W  8    // One pin lane
`define BUS_PHASES 9    // Clocks per bus cycle

// Opcode byte values, anything else is a no-op
`define OP_LDI  8'd1
`define OP_ADDI 8'd2
`define OP_STA  8'd3
`define OP_JMP  8'd4

`endif

// File: hdl/pin_bus_top.sv
// ############################
// Pin bus top level
// Processor behind an 8+8 pin interface
// ############################
`timescale 1ns/1ps

module pin_bus_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   ena,      // Not used
  input  cpu_bus_pkg::pin_byte_t ui_in,    // Not used
  input  cpu_bus_pkg::pin_byte_t uio_in,
  output cpu_bus_pkg::pin_byte_t uo_out,
  output cpu_bus_pkg::pin_byte_t uio_out,
  output cpu_bus_pkg::pin_byte_t uio_oe
);

  cpu_bus_pkg::bus_phase_e   phase;
  logic                      step;
  cpu_bus_pkg::cpu_bus_req_t bus_req;
  cpu_bus_pkg::word_t        rdata;

  bus_phase_ctrl u_phase_ctrl (
    .clk   (clk),
    .rst_n (rst_n),
    .phase (phase),
    .step  (step)
  );

  bus_out_serializer u_out_serializer (
    .clk     (clk),
    .rst_n   (rst_n),
    .phase   (phase),
    .bus_req (bus_req),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_oe  (uio_oe)
  );

  bus_in_assembler u_in_assembler (
    .clk    (clk),
    .rst_n  (rst_n),
    .phase  (phase),
    .uio_in (uio_in),
    .rdata  (rdata)
  );

  acc_cpu u_acc_cpu (
    .clk     (clk),
    .rst_n   (rst_n),
    .step    (step),
    .rdata   (rdata),
    .bus_req (bus_req)
  );

endmodule

// File: list.f
+incdir+hdl
hdl/cpu_bus_pkg.sv
hdl/bus_phase_ctrl.sv
hdl/bus_out_serializer.sv
hdl/bus_in_assembler.sv
hdl/acc_cpu.sv
hdl/pin_bus_top.sv
verification/tb_clk_gen.sv
verification/pin_bus_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the pin bus testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f list.f --top-module pin_bus_tb -o pin_bus_sim
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

sim_out=$(./obj_dir/pin_bus_sim 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -q '^TEST PASS$'; then
  echo "Simulation passed"
  exit 0
fi

echo "Simulation failed"
exit 1

// File: verification/pin_bus_tb.sv
// ############################
// Pin bus testbench
// Pin-level memory model and directed program tests
// ############################
`timescale 1ns/1ps
`include "cpu_bus_settings.svh"

module pin_bus_tb;

  localparam int MEM_WORDS     = 256;
  localparam int PROG_BASE     = 1;  // Reset word runs as a no-op, so pc starts one word in
  localparam int CYCLE_TIMEOUT = 3 * `BUS_PHASES;
  localparam int RESET_TIMEOUT = 16;

  logic                      clk;
  logic                      rst_n;
  logic                      rst_req = 1'b0;
  logic                      ena;
  cpu_bus_pkg::pin_byte_t    ui_in;
  cpu_bus_pkg::pin_byte_t    uio_in  = '0;
  cpu_bus_pkg::pin_byte_t    uo_out;
  cpu_bus_pkg::pin_byte_t    uio_out;
  cpu_bus_pkg::pin_byte_t    uio_oe;

  cpu_bus_pkg::word_t        mem [MEM_WORDS];  // Written by the tests only
  cpu_bus_pkg::cpu_bus_req_t cycle_q [$];      // Bus cycles rebuilt from the pins
  cpu_bus_pkg::cpu_bus_req_t mon_req;
  cpu_bus_pkg::word_t        rd_word;
  int                        ph;               // 0 is PH_STEP, 1..4 out, 5..8 in
  int                        lane;
  int                        mon_err_cnt = 0;
  int                        rd_idx = 0;
  int                        err_cnt = 0;
  int                        err_at_start;
  int                        tests_run = 0;
  int                        tests_failed = 0;
  int unsigned               lcg_state = 66;
  string                     cur_test;

  tb_clk_gen clk_rst (
    .rst_req (rst_req),
    .clk     (clk),
    .rst_n   (rst_n)
  );

  pin_bus_top DUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .ena     (ena),
    .ui_in   (ui_in),
    .uio_in  (uio_in),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_oe  (uio_oe)
  );

  function automatic int unsigned lcg_next(input int unsigned s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic cpu_bus_pkg::word_t make_instr(input cpu_bus_pkg::opcode_t op,
                                                    input cpu_bus_pkg::imm_t imm);
    return {op, imm};
  endfunction

  function automatic cpu_bus_pkg::word_t read_mem(input cpu_bus_pkg::word_t addr);
    if (addr < MEM_WORDS) begin
      return mem[addr[7:0]];
    end
    return '0;
  endfunction

  function automatic int errors_now();
    return err_cnt + mon_err_cnt;
  endfunction

  // Pin monitor and memory model on every falling edge
  always @(negedge clk) begin
    if (!rst_n) begin
      ph = 0;
      mon_req = '0;
      cycle_q.delete();
      uio_in = '0;
    end else begin
      ph = (ph == `BUS_PHASES - 1) ? 0 : ph + 1;
      if (ph >= 2 && ph <= 5) begin
        lane = ph - 2;  // Byte of the previous PH_OUT phase is on the pins now
        if (ph == 2) begin
          mon_req.rw = uio_oe[0];
        end
        mon_req.addr[lane*`CPU_PIN_W +: `CPU_PIN_W]  = uo_out;
        mon_req.wdata[lane*`CPU_PIN_W +: `CPU_PIN_W] = uio_out;
      end
      // Enable stays at the rw of the bus cycle being captured
      if (uio_oe != {`CPU_PIN_W{mon_req.rw}}) begin
        $display("mismatch %s uio_oe at address %h: expected %h, actual %h", cur_test,
                 mon_req.addr, {`CPU_PIN_W{mon_req.rw}}, uio_oe);
        mon_err_cnt++;
      end
      if (ph == 5) begin
        cycle_q.push_back(mon_req);
        if (mon_req.addr >= MEM_WORDS) begin
          $display("bus cycle to address %h is outside the memory model", mon_req.addr);
          mon_err_cnt++;
        end
        rd_word = read_mem(mon_req.addr);
      end
      if (ph >= 5) begin
        uio_in = rd_word[(ph-5)*`CPU_PIN_W +: `CPU_PIN_W];  // Least significant byte first
      end else begin
        uio_in = '0;
      end
    end
  end

  task automatic compare_word(input string what, input cpu_bus_pkg::word_t exp_val,
                              input cpu_bus_pkg::word_t act_val);
    if (act_val !== exp_val) begin
      $display("mismatch %s %s: expected %h, actual %h", cur_test, what, exp_val, act_val);
      err_cnt++;
    end
  endtask

  task automatic compare_byte(input string what, input cpu_bus_pkg::pin_byte_t exp_val,
                              input cpu_bus_pkg::pin_byte_t act_val);
    if (act_val !== exp_val) begin
      $display("mismatch %s %s: expected %h, actual %h", cur_test, what, exp_val, act_val);
      err_cnt++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test     = name;
    err_at_start = errors_now();
  endtask

  task automatic finish_test();
    int errs;
    errs = errors_now() - err_at_start;
    tests_run++;
    if (errs == 0) begin
      $display("test %s passed", cur_test);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", cur_test, errs);
    end
  endtask

  task automatic request_reset();
    @(posedge clk);
    rst_req = 1'b1;
    @(posedge clk);
    rst_req = 1'b0;
  endtask

  task automatic reset_dut();
    int waited;
    request_reset();
    waited = 0;
    while (!rst_n && waited < RESET_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (!rst_n) begin
      $display("%s: reset was not released within %0d clocks", cur_test, RESET_TIMEOUT);
      err_cnt++;
    end
    rd_idx = 0;
  endtask

  task automatic fill_memory();
    for (int i = 0; i < MEM_WORDS; i++) begin
      lcg_state = lcg_next(lcg_state);
      mem[i] = {8'h00, lcg_state[23:0] ^ 24'(i)};  // Opcode 0 is a no-op
    end
  endtask

  task automatic next_bus_cycle(output cpu_bus_pkg::cpu_bus_req_t req);
    int waited;
    waited = 0;
    while (rd_idx >= cycle_q.size() && waited < CYCLE_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (rd_idx < cycle_q.size()) begin
      req = cycle_q[rd_idx];
      rd_idx++;
    end else begin
      $display("%s: no bus cycle seen within %0d clocks", cur_test, CYCLE_TIMEOUT);
      err_cnt++;
      req = '0;
    end
  endtask

  task automatic expect_cycle(input string what, input cpu_bus_pkg::word_t exp_addr,
                              input cpu_bus_pkg::word_t exp_wdata, input logic exp_rw);
    cpu_bus_pkg::cpu_bus_req_t req;
    next_bus_cycle(req);
    compare_word({what, " address"}, exp_addr, req.addr);
    compare_word({what, " write data"}, exp_wdata, req.wdata);
    compare_byte({what, " uio_oe"}, {`CPU_PIN_W{exp_rw}}, {`CPU_PIN_W{req.rw}});
  endtask

  task automatic reset_state_test();
    int waited;
    bit released;
    start_test("reset_state");
    request_reset();
    waited   = 0;
    released = 1'b0;
    while (!released && waited < RESET_TIMEOUT) begin
      @(negedge clk);
      waited++;
      released = rst_n;  // Last pass checks the first clock out of reset
      compare_byte("uo_out", 8'h00, uo_out);
      compare_byte("uio_out", 8'h00, uio_out);
      compare_byte("uio_oe", 8'h00, uio_oe);
    end
    if (!released) begin
      $display("%s: reset was not released within %0d clocks", cur_test, RESET_TIMEOUT);
      err_cnt++;
    end
    finish_test();
  endtask

  task automatic fetch_order_test();
    start_test("fetch_order");
    fill_memory();
    reset_dut();
    for (int i = 0; i < 6; i++) begin
      expect_cycle($sformatf("fetch %0d", i), PROG_BASE + i, '0, 1'b0);
    end
    finish_test();
  endtask

  task automatic load_add_store_test();
    cpu_bus_pkg::word_t sum_exp;
    start_test("load_add_store");
    fill_memory();
    mem[PROG_BASE]     = make_instr(`OP_LDI, 24'd5);
    mem[PROG_BASE + 1] = make_instr(`OP_ADDI, 24'd7);
    mem[PROG_BASE + 2] = make_instr(`OP_STA, 24'h40);
    sum_exp = 32'd5 + 32'd7;
    reset_dut();
    expect_cycle("fetch ldi", PROG_BASE, '0, 1'b0);
    expect_cycle("fetch addi", PROG_BASE + 1, '0, 1'b0);
    expect_cycle("fetch sta", PROG_BASE + 2, '0, 1'b0);
    expect_cycle("store", 32'h40, sum_exp, 1'b1);
    expect_cycle("fetch after store", PROG_BASE + 3, '0, 1'b0);  // pc moved past STA
    finish_test();
  endtask

  task automatic byte_order_test();
    cpu_bus_pkg::cpu_bus_req_t req;
    cpu_bus_pkg::pin_byte_t    exp_bytes [4] = '{8'h56, 8'h34, 8'h12, 8'h00};
    start_test("byte_order");
    fill_memory();
    mem[PROG_BASE]     = make_instr(`OP_LDI, 24'h123456);
    mem[PROG_BASE + 1] = make_instr(`OP_STA, 24'h50);
    reset_dut();
    expect_cycle("fetch ldi", PROG_BASE, '0, 1'b0);
    expect_cycle("fetch sta", PROG_BASE + 1, '0, 1'b0);
    next_bus_cycle(req);
    compare_word("store address", 32'h50, req.addr);
    compare_byte("store uio_oe", 8'hFF, {`CPU_PIN_W{req.rw}});
    for (int k = 0; k < 4; k++) begin
      compare_byte($sformatf("write byte in phase %0d", k), exp_bytes[k],
                   req.wdata[k*`CPU_PIN_W +: `CPU_PIN_W]);
    end
    finish_test();
  endtask

  task automatic jump_test();
    start_test("jump");
    fill_memory();
    mem[PROG_BASE] = make_instr(`OP_JMP, 24'h20);
    reset_dut();
    expect_cycle("fetch jmp", PROG_BASE, '0, 1'b0);
    expect_cycle("jump target", 32'h20, '0, 1'b0);
    expect_cycle("after target", 32'h21, '0, 1'b0);
    expect_cycle("second after target", 32'h22, '0, 1'b0);
    finish_test();
  endtask

  task automatic add_chain_test();
    cpu_bus_pkg::imm_t  imm;
    cpu_bus_pkg::word_t sum_exp;
    start_test("add_chain");
    fill_memory();
    sum_exp = '0;
    for (int k = 0; k < 10; k++) begin
      lcg_state = lcg_next(lcg_state);
      imm = lcg_state[23:0];
      mem[PROG_BASE + k] = make_instr(`OP_ADDI, imm);
      sum_exp = sum_exp + cpu_bus_pkg::word_t'(imm);  // Wraps at 32 bits
    end
    mem[PROG_BASE + 10] = make_instr(`OP_STA, 24'h60);
    reset_dut();
    for (int k = 0; k < 11; k++) begin
      expect_cycle($sformatf("fetch %0d", k), PROG_BASE + k, '0, 1'b0);
    end
    expect_cycle("store sum", 32'h60, sum_exp, 1'b1);
    finish_test();
  endtask

  initial begin
    ena   = 1'b1;
    ui_in = '0;
    reset_state_test();
    fetch_order_test();
    load_add_store_test();
    byte_order_test();
    jump_test();
    add_chain_test();
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
             errors_now());
    if (tests_failed == 0 && errors_now() == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: verification/tb_clk_gen.sv
// ############################
// Testbench clock and reset
// ############################
`timescale 1ns/1ps

module tb_clk_gen (
  input  logic rst_req,  // Restarts the reset window
  output logic clk,
  output logic rst_n
);

  logic       clk_q   = 1'b0;
  logic [2:0] rst_cnt = 3'd4;  // Reset clocks still to go

  initial begin
    forever #5 clk_q = ~clk_q;  // 10 ns period
  end

  // Reset changes on falling edges, away from the DUT sampling edge
  always @(negedge clk_q) begin
    if (rst_req) begin
      rst_cnt <= 3'd4;
    end else if (rst_cnt != 3'd0) begin
      rst_cnt <= rst_cnt - 3'd1;
    end
  end

  assign clk   = clk_q;
  assign rst_n = (rst_cnt == 3'd0);

endmodule
